// File: verilog/ctrl_settings.svh
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// Instruction field widths
`define CTRL_OPCODE_W 6
`define CTRL_FUNCT_W 6

// Width of the per-state step counter
`define CTRL_STEP_W 3

// Fixed phase lengths in cycles
`define CTRL_FETCH_STEPS 4
`define CTRL_DECODE_STEPS 3

`endif

// File: verilog/isa_pkg.sv
package isa_pkg;

    `include "ctrl_settings.svh"

    // Major opcodes, R-type resolved further by funct
    typedef enum logic [`CTRL_OPCODE_W-1:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08
    } opcode_t;

    // R-type function codes
    typedef enum logic [`CTRL_FUNCT_W-1:0] {
        fn_sll = 6'h00,
        fn_srl = 6'h02,
        fn_sra = 6'h03,
        fn_jr  = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_slt = 6'h2a
    } funct_t;

    // Execute behaviour of an instruction
    typedef enum logic [3:0] {
        cls_add,
        cls_sub,
        cls_and,
        cls_slt,
        cls_addi,
        cls_jr,
        cls_sll,
        cls_srl,
        cls_sra,
        cls_illegal
    } instr_class_t;

endpackage

// File: verilog/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        st_reset,
        st_fetch,
        st_decode,
        st_alu,
        st_addi,
        st_slt,
        st_jr,
        st_shift_load,
        st_shift_run,
        st_close
    } ctrl_state_t;

    // Encodings fixed by the datapath ALU
    typedef enum logic [2:0] {
        alu_load = 3'd0,
        alu_add  = 3'd1,
        alu_sub  = 3'd2,
        alu_and  = 3'd3,
        alu_cmp  = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        b_reg    = 2'd0,
        b_four   = 2'd1,
        b_imm    = 2'd2,
        b_offset = 2'd3
    } alu_b_sel_t;

    typedef enum logic [1:0] {
        dst_rt = 2'd0,
        dst_rd = 2'd1
    } reg_dst_sel_t;

    // Register file write data mux
    typedef enum logic [2:0] {
        data_alu   = 3'd1,
        data_shift = 3'd4,
        data_lt    = 3'd6
    } data_src_sel_t;

    typedef enum logic [2:0] {
        sh_none        = 3'd0,
        sh_load        = 3'd1,
        sh_left        = 3'd2,
        sh_right_logic = 3'd3,
        sh_right_arith = 3'd4
    } shift_op_t;

endpackage

// File: verilog/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  isa_pkg::opcode_t      opcode,
    input  isa_pkg::funct_t       funct,
    output isa_pkg::instr_class_t instr_class
);

    always_comb begin
        instr_class = isa_pkg::cls_illegal;
        case (opcode)
            isa_pkg::op_rtype: begin
                case (funct)
                    isa_pkg::fn_add: instr_class = isa_pkg::cls_add;
                    isa_pkg::fn_sub: instr_class = isa_pkg::cls_sub;
                    isa_pkg::fn_and: instr_class = isa_pkg::cls_and;
                    isa_pkg::fn_slt: instr_class = isa_pkg::cls_slt;
                    isa_pkg::fn_jr: instr_class = isa_pkg::cls_jr;
                    isa_pkg::fn_sll: instr_class = isa_pkg::cls_sll;
                    isa_pkg::fn_srl: instr_class = isa_pkg::cls_srl;
                    isa_pkg::fn_sra: instr_class = isa_pkg::cls_sra;
                    // break, rte and anything else
                    default: instr_class = isa_pkg::cls_illegal;
                endcase
            end
            isa_pkg::op_addi: begin
                instr_class = isa_pkg::cls_addi;
            end
            default: begin
                instr_class = isa_pkg::cls_illegal;
            end
        endcase
    end

endmodule

// File: verilog/control_sequencer.sv
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module control_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  isa_pkg::instr_class_t   instr_class,
    output ctrl_pkg::ctrl_state_t   state,
    output logic [`CTRL_STEP_W-1:0] step,
    output isa_pkg::instr_class_t   cur_class
);

    // Final step index of each state
    localparam logic [`CTRL_STEP_W-1:0] fetch_last  = `CTRL_FETCH_STEPS - 1;
    localparam logic [`CTRL_STEP_W-1:0] decode_last = `CTRL_DECODE_STEPS - 1;
    localparam logic [`CTRL_STEP_W-1:0] alu_last    = 2;
    localparam logic [`CTRL_STEP_W-1:0] slt_last    = 1;
    localparam logic [`CTRL_STEP_W-1:0] shift_last  = 1;
    localparam logic [`CTRL_STEP_W-1:0] single_last = 0;

    logic [`CTRL_STEP_W-1:0] last_step;
    ctrl_pkg::ctrl_state_t   next_state;
    logic                    state_done;

    always_comb begin
        case (state)
            ctrl_pkg::st_fetch: last_step = fetch_last;
            ctrl_pkg::st_decode: last_step = decode_last;
            ctrl_pkg::st_alu,
            ctrl_pkg::st_addi: last_step = alu_last;
            ctrl_pkg::st_slt: last_step = slt_last;
            ctrl_pkg::st_shift_run: last_step = shift_last;
            default: last_step = single_last;
        endcase
    end

    assign state_done = (step == last_step);

    // Successor taken once the current state has run all its steps
    always_comb begin
        case (state)
            ctrl_pkg::st_reset: next_state = ctrl_pkg::st_fetch;
            ctrl_pkg::st_fetch: next_state = ctrl_pkg::st_decode;
            ctrl_pkg::st_decode: begin
                case (instr_class)
                    isa_pkg::cls_add,
                    isa_pkg::cls_sub,
                    isa_pkg::cls_and: next_state = ctrl_pkg::st_alu;
                    isa_pkg::cls_addi: next_state = ctrl_pkg::st_addi;
                    isa_pkg::cls_slt: next_state = ctrl_pkg::st_slt;
                    isa_pkg::cls_jr: next_state = ctrl_pkg::st_jr;
                    isa_pkg::cls_sll,
                    isa_pkg::cls_srl,
                    isa_pkg::cls_sra: next_state = ctrl_pkg::st_shift_load;
                    // Unsupported code skips execute
                    default: next_state = ctrl_pkg::st_close;
                endcase
            end
            ctrl_pkg::st_shift_load: next_state = ctrl_pkg::st_shift_run;
            ctrl_pkg::st_close: next_state = ctrl_pkg::st_fetch;
            ctrl_pkg::st_alu,
            ctrl_pkg::st_addi,
            ctrl_pkg::st_slt,
            ctrl_pkg::st_jr,
            ctrl_pkg::st_shift_run: next_state = ctrl_pkg::st_close;
            default: next_state = ctrl_pkg::st_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ctrl_pkg::st_reset;
            step      <= '0;
            cur_class <= isa_pkg::cls_illegal;
        end else begin
            if (state_done) begin
                state <= next_state;
                step  <= '0;
            end else begin
                step <= step + 1'b1;
            end
            // Held for the whole execute phase
            if (state == ctrl_pkg::st_decode && state_done) begin
                cur_class <= instr_class;
            end
        end
    end

endmodule

// File: verilog/control_signal_encoder.sv
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module control_signal_encoder (
    input  logic                    clk,
    input  logic                    reset,
    input  ctrl_pkg::ctrl_state_t   state,
    input  logic [`CTRL_STEP_W-1:0] step,
    input  isa_pkg::instr_class_t   cur_class,
    output logic                    pc_w,
    output logic                    ir_w,
    output logic                    reg_ab_w,
    output logic                    alu_out_w,
    output logic                    reg_w,
    output logic                    alu_src_a,
    output logic                    rst_out,
    output ctrl_pkg::alu_b_sel_t    alu_src_b,
    output ctrl_pkg::alu_op_t       alu_op,
    output ctrl_pkg::reg_dst_sel_t  reg_dst,
    output ctrl_pkg::data_src_sel_t data_src,
    output ctrl_pkg::shift_op_t     shift_control
);

    localparam logic [`CTRL_STEP_W-1:0] fetch_last = `CTRL_FETCH_STEPS - 1;
    localparam logic [`CTRL_STEP_W-1:0] write_step = 2;

    logic                    nxt_pc_w;
    logic                    nxt_ir_w;
    logic                    nxt_reg_ab_w;
    logic                    nxt_alu_out_w;
    logic                    nxt_reg_w;
    logic                    nxt_alu_src_a;
    logic                    nxt_rst_out;
    ctrl_pkg::alu_b_sel_t    nxt_alu_src_b;
    ctrl_pkg::alu_op_t       nxt_alu_op;
    ctrl_pkg::reg_dst_sel_t  nxt_reg_dst;
    ctrl_pkg::data_src_sel_t nxt_data_src;
    ctrl_pkg::shift_op_t     nxt_shift_control;

    always_comb begin
        nxt_pc_w          = 1'b0;
        nxt_ir_w          = 1'b0;
        nxt_reg_ab_w      = 1'b0;
        nxt_alu_out_w     = 1'b0;
        nxt_reg_w         = 1'b0;
        nxt_rst_out       = 1'b0;
        nxt_alu_src_a     = 1'b0;
        nxt_alu_src_b     = ctrl_pkg::b_reg;
        nxt_alu_op        = ctrl_pkg::alu_load;
        nxt_reg_dst       = ctrl_pkg::dst_rt;
        nxt_data_src      = ctrl_pkg::data_alu;
        nxt_shift_control = ctrl_pkg::sh_none;
        case (state)
            ctrl_pkg::st_reset: begin
                nxt_rst_out = 1'b1;
            end
            ctrl_pkg::st_fetch: begin
                // PC + 4 while memory is read
                nxt_alu_op    = ctrl_pkg::alu_add;
                nxt_alu_src_b = ctrl_pkg::b_four;
                if (step == fetch_last) begin
                    nxt_pc_w = 1'b1;
                    nxt_ir_w = 1'b1;
                end
            end
            ctrl_pkg::st_decode: begin
                // Branch target precomputed into ALUOut
                nxt_alu_op    = ctrl_pkg::alu_add;
                nxt_alu_src_b = ctrl_pkg::b_offset;
                if (step == '0) begin
                    nxt_reg_ab_w  = 1'b1;
                    nxt_alu_out_w = 1'b1;
                end
            end
            ctrl_pkg::st_alu: begin
                nxt_alu_src_a = 1'b1;
                nxt_reg_dst   = ctrl_pkg::dst_rd;
                case (cur_class)
                    isa_pkg::cls_sub: nxt_alu_op = ctrl_pkg::alu_sub;
                    isa_pkg::cls_and: nxt_alu_op = ctrl_pkg::alu_and;
                    default: nxt_alu_op = ctrl_pkg::alu_add;
                endcase
                nxt_alu_out_w = (step == '0);
                nxt_reg_w     = (step == write_step);
            end
            ctrl_pkg::st_addi: begin
                nxt_alu_src_a = 1'b1;
                nxt_alu_src_b = ctrl_pkg::b_imm;
                nxt_alu_op    = ctrl_pkg::alu_add;
                nxt_alu_out_w = (step == '0);
                nxt_reg_w     = (step == write_step);
            end
            ctrl_pkg::st_slt: begin
                // Result comes from the LT flag, written in the first step
                nxt_alu_src_a = 1'b1;
                nxt_alu_op    = ctrl_pkg::alu_cmp;
                nxt_data_src  = ctrl_pkg::data_lt;
                nxt_reg_dst   = ctrl_pkg::dst_rd;
                nxt_alu_out_w = 1'b1;
                nxt_reg_w     = (step == '0);
            end
            ctrl_pkg::st_jr: begin
                // ALU passes rs straight to the PC
                nxt_alu_src_a = 1'b1;
                nxt_alu_op    = ctrl_pkg::alu_load;
                nxt_reg_dst   = ctrl_pkg::dst_rd;
                nxt_pc_w      = 1'b1;
            end
            ctrl_pkg::st_shift_load: begin
                nxt_shift_control = ctrl_pkg::sh_load;
                nxt_data_src      = ctrl_pkg::data_shift;
                nxt_reg_dst       = ctrl_pkg::dst_rd;
            end
            ctrl_pkg::st_shift_run: begin
                nxt_data_src = ctrl_pkg::data_shift;
                nxt_reg_dst  = ctrl_pkg::dst_rd;
                if (step == '0) begin
                    case (cur_class)
                        isa_pkg::cls_sll: nxt_shift_control = ctrl_pkg::sh_left;
                        isa_pkg::cls_srl: nxt_shift_control = ctrl_pkg::sh_right_logic;
                        isa_pkg::cls_sra: nxt_shift_control = ctrl_pkg::sh_right_arith;
                        default: nxt_shift_control = ctrl_pkg::sh_none;
                    endcase
                end else begin
                    nxt_reg_w = 1'b1;
                end
            end
            default: begin
                // Close step keeps every default
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_w      <= 1'b0;
            ir_w      <= 1'b0;
            reg_ab_w  <= 1'b0;
            alu_out_w <= 1'b0;
            reg_w     <= 1'b0;
            rst_out   <= 1'b1;
        end else begin
            pc_w      <= nxt_pc_w;
            ir_w      <= nxt_ir_w;
            reg_ab_w  <= nxt_reg_ab_w;
            alu_out_w <= nxt_alu_out_w;
            reg_w     <= nxt_reg_w;
            rst_out   <= nxt_rst_out;
        end
    end

    always_ff @(posedge clk) begin
        alu_src_a     <= nxt_alu_src_a;
        alu_src_b     <= nxt_alu_src_b;
        alu_op        <= nxt_alu_op;
        reg_dst       <= nxt_reg_dst;
        data_src      <= nxt_data_src;
        shift_control <= nxt_shift_control;
    end

endmodule

// File: verilog/ctrl_unit.sv
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module ctrl_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`CTRL_OPCODE_W-1:0] opcode,
    input  logic [`CTRL_FUNCT_W-1:0]  funct,
    output logic                      pc_w,
    output logic                      ir_w,
    output logic                      reg_ab_w,
    output logic                      alu_out_w,
    output logic                      reg_w,
    output logic                      alu_src_a,
    output logic                      rst_out,
    output ctrl_pkg::alu_b_sel_t      alu_src_b,
    output ctrl_pkg::alu_op_t         alu_op,
    output ctrl_pkg::reg_dst_sel_t    reg_dst,
    output ctrl_pkg::data_src_sel_t   data_src,
    output ctrl_pkg::shift_op_t       shift_control
);

    isa_pkg::opcode_t        opcode_field;
    isa_pkg::funct_t         funct_field;
    isa_pkg::instr_class_t   instr_class;
    isa_pkg::instr_class_t   cur_class;
    ctrl_pkg::ctrl_state_t   state;
    logic [`CTRL_STEP_W-1:0] step;

    // Raw IR fields may carry codes outside the enums
    assign opcode_field = isa_pkg::opcode_t'(opcode);
    assign funct_field  = isa_pkg::funct_t'(funct);

    instr_decoder instr_decoder_inst (
        .opcode      (opcode_field),
        .funct       (funct_field),
        .instr_class (instr_class)
    );

    control_sequencer control_sequencer_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_class (instr_class),
        .state       (state),
        .step        (step),
        .cur_class   (cur_class)
    );

    control_signal_encoder control_signal_encoder_inst (
        .clk           (clk),
        .reset         (reset),
        .state         (state),
        .step          (step),
        .cur_class     (cur_class),
        .pc_w          (pc_w),
        .ir_w          (ir_w),
        .reg_ab_w      (reg_ab_w),
        .alu_out_w     (alu_out_w),
        .reg_w         (reg_w),
        .alu_src_a     (alu_src_a),
        .rst_out       (rst_out),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .reg_dst       (reg_dst),
        .data_src      (data_src),
        .shift_control (shift_control)
    );

endmodule

// File: sim/ctrl_checker.sv
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module ctrl_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`CTRL_OPCODE_W-1:0] opcode,
    input  logic [`CTRL_FUNCT_W-1:0]  funct,
    input  logic                      pc_w,
    input  logic                      ir_w,
    input  logic                      reg_ab_w,
    input  logic                      alu_out_w,
    input  logic                      reg_w,
    input  logic                      alu_src_a,
    input  logic                      rst_out,
    input  ctrl_pkg::alu_b_sel_t      alu_src_b,
    input  ctrl_pkg::alu_op_t         alu_op,
    input  ctrl_pkg::reg_dst_sel_t    reg_dst,
    input  ctrl_pkg::data_src_sel_t   data_src,
    input  ctrl_pkg::shift_op_t       shift_control,
    output int                        mismatches,
    output int                        missing_ir
);

    localparam int decode_first = `CTRL_FETCH_STEPS;
    localparam int exec_first   = `CTRL_FETCH_STEPS + `CTRL_DECODE_STEPS;

    int                    mismatch_count = 0;
    int                    missing_count = 0;
    logic                  seen_reset = 1'b0;
    int                    lead = 0;
    int                    pos = 0;
    int                    since_ir = 0;
    isa_pkg::instr_class_t cls = isa_pkg::cls_illegal;

    assign mismatches = mismatch_count;
    assign missing_ir = missing_count;

    function automatic isa_pkg::instr_class_t classify(
        input logic [`CTRL_OPCODE_W-1:0] op,
        input logic [`CTRL_FUNCT_W-1:0]  fn
    );
        isa_pkg::instr_class_t c;
        c = isa_pkg::cls_illegal;
        if (op == isa_pkg::op_addi) begin
            c = isa_pkg::cls_addi;
        end else if (op == isa_pkg::op_rtype) begin
            case (fn)
                isa_pkg::fn_add: c = isa_pkg::cls_add;
                isa_pkg::fn_sub: c = isa_pkg::cls_sub;
                isa_pkg::fn_and: c = isa_pkg::cls_and;
                isa_pkg::fn_slt: c = isa_pkg::cls_slt;
                isa_pkg::fn_jr: c = isa_pkg::cls_jr;
                isa_pkg::fn_sll: c = isa_pkg::cls_sll;
                isa_pkg::fn_srl: c = isa_pkg::cls_srl;
                isa_pkg::fn_sra: c = isa_pkg::cls_sra;
                default: c = isa_pkg::cls_illegal;
            endcase
        end
        return c;
    endfunction

    function automatic int execute_length(input isa_pkg::instr_class_t c);
        int len;
        case (c)
            isa_pkg::cls_illegal: len = 0;
            isa_pkg::cls_jr: len = 1;
            isa_pkg::cls_slt: len = 2;
            default: len = 3;
        endcase
        return len;
    endfunction

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
            mismatch_count++;
        end
    endtask

    task automatic compare_strobes(input logic [4:0] exp);
        compare("pc_w", pc_w, exp[4]);
        compare("ir_w", ir_w, exp[3]);
        compare("reg_ab_w", reg_ab_w, exp[2]);
        compare("alu_out_w", alu_out_w, exp[1]);
        compare("reg_w", reg_w, exp[0]);
    endtask

    task automatic check_execute(input int e, output logic [4:0] exp);
        exp = 5'b00000;
        case (cls)
            isa_pkg::cls_slt: begin
                exp = (e == 0) ? 5'b00011 : 5'b00010;
                compare("alu_op", alu_op, ctrl_pkg::alu_cmp);
                compare("data_src", data_src, ctrl_pkg::data_lt);
                compare("reg_dst", reg_dst, ctrl_pkg::dst_rd);
            end
            isa_pkg::cls_jr: begin
                exp = 5'b10000;
            end
            isa_pkg::cls_sll, isa_pkg::cls_srl, isa_pkg::cls_sra: begin
                compare("data_src", data_src, ctrl_pkg::data_shift);
                compare("reg_dst", reg_dst, ctrl_pkg::dst_rd);
                if (e == 0) begin
                    compare("shift_control", shift_control, ctrl_pkg::sh_load);
                end else if (e == 1) begin
                    if (cls == isa_pkg::cls_sll)
                        compare("shift_control", shift_control, ctrl_pkg::sh_left);
                    else if (cls == isa_pkg::cls_srl)
                        compare("shift_control", shift_control, ctrl_pkg::sh_right_logic);
                    else
                        compare("shift_control", shift_control, ctrl_pkg::sh_right_arith);
                end else begin
                    exp = 5'b00001;
                    compare("shift_control", shift_control, ctrl_pkg::sh_none);
                end
            end
            default: begin
                // add, sub, and, addi
                if (e == 0) exp = 5'b00010;
                if (e == 2) exp = 5'b00001;
                if (cls == isa_pkg::cls_sub)
                    compare("alu_op", alu_op, ctrl_pkg::alu_sub);
                else if (cls == isa_pkg::cls_and)
                    compare("alu_op", alu_op, ctrl_pkg::alu_and);
                else
                    compare("alu_op", alu_op, ctrl_pkg::alu_add);
                if (cls == isa_pkg::cls_addi) begin
                    compare("reg_dst", reg_dst, ctrl_pkg::dst_rt);
                    compare("alu_src_b", alu_src_b, ctrl_pkg::b_imm);
                end else begin
                    compare("reg_dst", reg_dst, ctrl_pkg::dst_rd);
                    compare("alu_src_b", alu_src_b, ctrl_pkg::b_reg);
                    compare("alu_src_a", alu_src_a, 1'b1);
                end
            end
        endcase
    endtask

    task automatic check_cycle();
        logic [4:0] exp;
        int         e;
        exp = 5'b00000;
        e = pos - exec_first;
        compare("rst_out", rst_out, 1'b0);
        if (pos < decode_first) begin
            if (pos == decode_first - 1) exp = 5'b11000;
            compare("alu_op", alu_op, ctrl_pkg::alu_add);
            compare("alu_src_a", alu_src_a, 1'b0);
            compare("alu_src_b", alu_src_b, ctrl_pkg::b_four);
            compare("data_src", data_src, ctrl_pkg::data_alu);
        end else if (pos < exec_first) begin
            if (pos == decode_first) begin
                exp = 5'b00110;
                cls = classify(opcode, funct);
            end
            compare("alu_src_a", alu_src_a, 1'b0);
            compare("alu_src_b", alu_src_b, ctrl_pkg::b_offset);
        end else if (e < execute_length(cls)) begin
            check_execute(e, exp);
        end
        compare_strobes(exp);
        // Close cycle ends the instruction
        if (pos >= exec_first && e == execute_length(cls)) pos = 0;
        else pos++;
    endtask

    task automatic check_reset_values();
        compare("rst_out", rst_out, 1'b1);
        compare_strobes(5'b00000);
    endtask

    // Samples are the values registered at the previous edge
    always @(posedge clk) begin
        if (reset) begin
            if (seen_reset) check_reset_values();
            seen_reset = 1'b1;
            lead = 2;
            since_ir = 0;
        end else if (lead > 0) begin
            check_reset_values();
            lead--;
            pos = 0;
        end else if (seen_reset) begin
            check_cycle();
            if (ir_w) since_ir = 0;
            else since_ir++;
            if (since_ir == 16) begin
                $display("ERROR: no ir_w pulse within 16 cycles at %0t", $time);
                missing_count++;
                since_ir = 0;
            end
        end
    end

endmodule

// File: sim/tb_ctrl_unit.sv
`timescale 1ns/10ps

`include "ctrl_settings.svh"

module tb_ctrl_unit;

    localparam int num_instr  = 200;
    localparam int ir_timeout = 32;

    logic                      clk;
    logic                      reset;
    logic [`CTRL_OPCODE_W-1:0] opcode;
    logic [`CTRL_FUNCT_W-1:0]  funct;
    logic                      pc_w;
    logic                      ir_w;
    logic                      reg_ab_w;
    logic                      alu_out_w;
    logic                      reg_w;
    logic                      alu_src_a;
    logic                      rst_out;
    ctrl_pkg::alu_b_sel_t      alu_src_b;
    ctrl_pkg::alu_op_t         alu_op;
    ctrl_pkg::reg_dst_sel_t    reg_dst;
    ctrl_pkg::data_src_sel_t   data_src;
    ctrl_pkg::shift_op_t       shift_control;

    logic [31:0] lcg_state;
    int          mismatches;
    int          missing_ir;
    int          wait_timeouts;
    int          i;
    bit          ok;

    ctrl_unit ctrl_unit_inst (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .pc_w          (pc_w),
        .ir_w          (ir_w),
        .reg_ab_w      (reg_ab_w),
        .alu_out_w     (alu_out_w),
        .reg_w         (reg_w),
        .alu_src_a     (alu_src_a),
        .rst_out       (rst_out),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .reg_dst       (reg_dst),
        .data_src      (data_src),
        .shift_control (shift_control)
    );

    ctrl_checker ctrl_checker_inst (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .pc_w          (pc_w),
        .ir_w          (ir_w),
        .reg_ab_w      (reg_ab_w),
        .alu_out_w     (alu_out_w),
        .reg_w         (reg_w),
        .alu_src_a     (alu_src_a),
        .rst_out       (rst_out),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .reg_dst       (reg_dst),
        .data_src      (data_src),
        .shift_control (shift_control),
        .mismatches    (mismatches),
        .missing_ir    (missing_ir)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw_instruction();
        logic [31:0] r;
        lcg_state = lcg_next(lcg_state);
        r = lcg_state;
        funct = r[13:8];
        if (r[18:16] == 3'd0) begin
            if (r[20]) begin
                // Foreign major opcode
                opcode = r[29:24];
                if (opcode == 6'h00 || opcode == 6'h08) begin
                    opcode = opcode | 6'h10;
                end
            end else begin
                opcode = 6'h00;
                case (r[23:21])
                    3'd0: funct = 6'h01;
                    3'd1: funct = 6'h0d;
                    3'd2: funct = 6'h10;
                    3'd3: funct = 6'h12;
                    3'd4: funct = 6'h18;
                    3'd5: funct = 6'h1a;
                    3'd6: funct = 6'h25;
                    default: funct = 6'h27;
                endcase
            end
        end else begin
            opcode = isa_pkg::op_rtype;
            case (r[31:20] % 12'd9)
                12'd0: funct = isa_pkg::fn_add;
                12'd1: funct = isa_pkg::fn_sub;
                12'd2: funct = isa_pkg::fn_and;
                12'd3: funct = isa_pkg::fn_slt;
                12'd4: funct = isa_pkg::fn_jr;
                12'd5: funct = isa_pkg::fn_sll;
                12'd6: funct = isa_pkg::fn_srl;
                12'd7: funct = isa_pkg::fn_sra;
                // addi keeps the random funct bits
                default: opcode = isa_pkg::op_addi;
            endcase
        end
    endtask

    task automatic wait_for_ir_w(output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < ir_timeout && !seen; n++) begin
            @(negedge clk);
            if (ir_w) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("ERROR: ir_w did not pulse within %0d cycles at %0t", ir_timeout, $time);
        end
    endtask

    initial begin
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        lcg_state = 32'hbfae;
        wait_timeouts = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Next instruction goes out right after each fetch completes
        for (i = 0; i < num_instr && wait_timeouts == 0; i++) begin
            wait_for_ir_w(ok);
            if (ok) begin
                draw_instruction();
            end else begin
                wait_timeouts++;
            end
        end
        if (wait_timeouts == 0) begin
            wait_for_ir_w(ok);
            if (!ok) begin
                wait_timeouts++;
            end
        end
        repeat (2) @(posedge clk);

        $display("errors: mismatches=%0d missing_ir_w=%0d wait_timeouts=%0d",
                 mismatches, missing_ir, wait_timeouts);
        if (mismatches + missing_ir + wait_timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/control_sequencer.sv
verilog/control_signal_encoder.sv
verilog/ctrl_unit.sv
sim/ctrl_checker.sv
sim/tb_ctrl_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ctrl_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
    -f sources.f --top-module tb_ctrl_unit -Mdir obj_dir -o tb_ctrl_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ctrl_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "No result line in $LOG"
    exit 1
fi
exit 0
